// File: Bender.yml
package:
  name: otp_part_buf

sources:
  # Design sources in compile order
  - include_dirs:
      - include
    files:
      - verilog/otp_part_pkg.sv
      - verilog/otp_buf_if.sv
      - verilog/otp_part_fsm.sv
      - verilog/otp_part_buf_regs.sv
      - verilog/otp_part_access.sv
      - verilog/otp_part_buf.sv
  # Checker and testbench
  - target: test
    include_dirs:
      - include
    files:
      - tb/otp_part_buf_chk.sv
      - tb/tb_otp_part_buf.sv

// File: include/otp_part_cfg.svh
// OTP partition sizing
`ifndef OTP_PART_CFG_SVH
`define OTP_PART_CFG_SVH

// One partition block, as returned by a single OTP read
`define OTP_BLOCK_W 64

// Blocks held in the buffer registers
`define OTP_NUM_BLOCKS 4

// Block index width
`define OTP_CNT_W 2

// Byte offset of the partition inside the OTP macro
`define OTP_PART_OFFSET 'h40

// The OTP macro is addressed in 16-bit halfwords
`define OTP_ADDR_W 10
`define OTP_ADDR_SHIFT 1

// Full buffered partition, block 0 in the low bits
`define OTP_PART_W (`OTP_NUM_BLOCKS * `OTP_BLOCK_W)

`endif

// File: otp_part_buf.f
+incdir+include
verilog/otp_part_pkg.sv
verilog/otp_buf_if.sv
verilog/otp_part_fsm.sv
verilog/otp_part_buf_regs.sv
verilog/otp_part_access.sv
verilog/otp_part_buf.sv
tb/otp_part_buf_chk.sv
tb/tb_otp_part_buf.sv

// File: tb/otp_part_buf_chk.sv
// Partition FSM assertions
`timescale 1ns/1ps
`default_nettype none

`include "otp_part_cfg.svh"

module otp_part_buf_chk
  import otp_part_pkg::*;
(
  input logic                   clk_i,
  input logic                   rst_ni,
  input state_e                 state_q,
  input logic                   escalate_en_i,
  input logic                   otp_req_o,
  input logic                   otp_gnt_i,
  input logic [`OTP_ADDR_W-1:0] otp_addr_o,
  input logic                   cnsty_chk_ack_o
);

  // Assertion failures so far
  int fail_cnt = 0;

  // No OTP traffic once locked down
  req_low_in_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == ErrorSt |-> !otp_req_o)
    else begin
      $error("otp_req_o is high in ErrorSt");
      fail_cnt++;
    end

  // Escalation is terminal from any state
  esc_to_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalate_en_i |=> state_q == ErrorSt)
    else begin
      $error("escalation did not reach ErrorSt");
      fail_cnt++;
    end

  // Ack belongs to the check and never to initialization
  no_ack_in_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == InitSt || state_q == InitWaitSt) |-> !cnsty_chk_ack_o)
    else begin
      $error("cnsty_chk_ack_o is high during initialization");
      fail_cnt++;
    end

  // Address held while the macro withholds the grant
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_o && !otp_gnt_i |=> $stable(otp_addr_o))
    else begin
      $error("otp_addr_o changed while a request waited for its grant");
      fail_cnt++;
    end

endmodule : otp_part_buf_chk

bind otp_part_fsm otp_part_buf_chk u_chk (.*);

`default_nettype wire

// File: tb/tb_otp_part_buf.sv
// Buffered OTP partition testbench
`timescale 1ns/1ps
`default_nettype none

`include "otp_part_cfg.svh"

module tb_otp_part_buf
  import otp_part_pkg::*;
();

  localparam int num_tests   = 6;
  localparam int clk_period  = 40;
  localparam int wait_limit  = 100;
  localparam int corrupt_blk = 1;
  localparam int base_addr   = `OTP_PART_OFFSET / 2;

  logic clk_i, rst_ni, init_req_i, cnsty_chk_req_i, check_byp_en_i, escalate_en_i;
  logic read_lock_i, write_lock_i, init_done_o, cnsty_chk_ack_o, fsm_err_o;
  logic read_lock_o, write_lock_o, otp_req_o, otp_gnt_i, otp_rvalid_i;
  otp_err_e error_o, otp_err_i;
  logic [`OTP_PART_W-1:0]  data_o;
  logic [`OTP_ADDR_W-1:0]  otp_addr_o;
  logic [`OTP_BLOCK_W-1:0] otp_rdata_i;

  // Test table with one entry per test
  string                   t_name     [num_tests];
  logic [`OTP_BLOCK_W-1:0] t_data     [num_tests][`OTP_NUM_BLOCKS];
  int                      t_err_blk  [num_tests];
  otp_err_e                t_err_code [num_tests];
  logic                    t_corrupt  [num_tests];
  logic                    t_byp      [num_tests];
  logic                    t_esc      [num_tests];
  logic                    t_rd_lock  [num_tests];
  logic                    t_wr_lock  [num_tests];
  otp_err_e                t_exp_err  [num_tests];

  logic [31:0] lfsr_q;
  int cur, exp_blk, err_cnt, check_cnt, fsm_err_cnt, ack_cnt, gnt_wait, rd_idx;
  logic in_check, done_seen, rd_pending, req_seen;

  otp_part_buf otp_part_buf_i (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Own check failures plus those of the bound FSM assertions
  function automatic int total_errors();
    return err_cnt + otp_part_buf_i.u_fsm.u_chk.fail_cnt;
  endfunction

  task automatic add_entry(input int i, input string name, input int err_blk,
                           input otp_err_e err_code, input logic corrupt, input logic byp,
                           input logic esc, input logic rd, input logic wr, input otp_err_e exp);
    t_name[i] = name;
    t_err_blk[i] = err_blk;
    t_err_code[i] = err_code;
    t_corrupt[i] = corrupt;
    t_byp[i] = byp;
    t_esc[i] = esc;
    t_rd_lock[i] = rd;
    t_wr_lock[i] = wr;
    t_exp_err[i] = exp;
    for (int b = 0; b < `OTP_NUM_BLOCKS; b++) begin
      t_data[i][b] = take_bits(`OTP_BLOCK_W);
    end
  endtask

  task automatic check_val(input string what, input logic [`OTP_PART_W-1:0] exp,
                           input logic [`OTP_PART_W-1:0] act);
    check_cnt++;
    assert (act === exp)
      else begin
        $display("[ERROR] %s %s: expected %0h, actual %0h", t_name[cur], what, exp, act);
        err_cnt++;
      end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // Ends on the ack and also on init_done_o outside a check
  task automatic wait_status(input logic for_check);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(cnsty_chk_ack_o || (!for_check && init_done_o)) && n < wait_limit);
    if (!(cnsty_chk_ack_o || (!for_check && init_done_o))) begin
      $display("Test %s timed out waiting for the partition to respond", t_name[cur]);
      err_cnt++;
    end
  endtask

  task automatic apply_reset();
    next_cycle();
    rst_ni = 1'b0;
    {init_req_i, cnsty_chk_req_i, check_byp_en_i, escalate_en_i} = '0;
    {read_lock_i, write_lock_i, in_check, done_seen, rd_pending, req_seen} = '0;
    fsm_err_cnt = 0;
    ack_cnt = 0;
    repeat (10) next_cycle();
    rst_ni = 1'b1;
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // OTP model and monitor
  ////////////////////////////////////////////////////////////

  // Grant after 0 to 3 cycles and rvalid one cycle after the grant
  always @(posedge clk_i) begin
    #1;
    otp_gnt_i    = 1'b0;
    otp_rvalid_i = 1'b0;
    otp_err_i    = NoError;
    if (rd_pending) begin
      rd_pending   = 1'b0;
      otp_rvalid_i = 1'b1;
      otp_rdata_i  = t_data[cur][rd_idx];
      if (in_check && t_corrupt[cur] && rd_idx == corrupt_blk) begin
        otp_rdata_i = otp_rdata_i ^ `OTP_BLOCK_W'('h100);
      end
      // Injected errors only hit the initialization readout
      if (!in_check && rd_idx == t_err_blk[cur]) begin
        otp_err_i = t_err_code[cur];
      end
    end else if (otp_req_o) begin
      if (!req_seen) begin
        req_seen = 1'b1;
        gnt_wait = int'(take_bits(2));
      end
      if (gnt_wait == 0) begin
        check_val("otp_addr_o", base_addr + 4 * exp_blk, otp_addr_o);
        otp_gnt_i  = 1'b1;
        req_seen   = 1'b0;
        rd_pending = 1'b1;
        rd_idx     = (int'(otp_addr_o) - base_addr) / 4;
        if (rd_idx < 0 || rd_idx >= `OTP_NUM_BLOCKS) begin
          rd_idx = 0;
        end
        exp_blk++;
      end else begin
        gnt_wait--;
      end
    end else begin
      req_seen = 1'b0;
    end
  end

  // Counts status pulses and checks that a locked partition shows no data
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (fsm_err_o) begin
        fsm_err_cnt++;
      end
      if (cnsty_chk_ack_o) begin
        ack_cnt++;
      end
      if (init_done_o) begin
        done_seen = 1'b1;
      end else begin
        check_val("read_lock_o while locked", 1, read_lock_o);
        check_val("write_lock_o while locked", 1, write_lock_o);
        check_val("data_o while locked", 0, data_o);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int i);
    int errs_before;
    logic init_fails;
    logic [`OTP_PART_W-1:0] exp_data;
    errs_before = total_errors();
    cur = i;
    exp_data = {t_data[i][3], t_data[i][2], t_data[i][1], t_data[i][0]};
    // Only a corrected ECC error lets initialization finish
    init_fails = (t_err_blk[i] >= 0) && (t_err_code[i] != MacroEccCorrError);
    apply_reset();
    check_val("error_o after reset", NoError, error_o);
    check_val("ack after reset", 0, cnsty_chk_ack_o);
    check_val("otp_req_o after reset", 0, otp_req_o);
    exp_blk = 0;
    next_cycle();
    read_lock_i = t_rd_lock[i];
    write_lock_i = t_wr_lock[i];
    check_byp_en_i = t_byp[i];
    init_req_i = 1'b1;
    next_cycle();
    init_req_i = 1'b0;
    wait_status(1'b0);
    if (init_fails) begin
      repeat (2) @(negedge clk_i);
      check_val("init_done_o ever high", 0, done_seen);
    end else begin
      check_val("data_o after init", exp_data, data_o);
      check_val("error_o after init", (t_err_blk[i] >= 0) ? t_err_code[i] : NoError, error_o);
      check_val("read_lock_o", t_rd_lock[i], read_lock_o);
      check_val("write_lock_o", t_wr_lock[i], write_lock_o);
      next_cycle();
      if (t_esc[i]) begin
        escalate_en_i = 1'b1;
        next_cycle();
        escalate_en_i = 1'b0;
        repeat (2) @(negedge clk_i);
        check_val("init_done_o after escalation", 0, init_done_o);
      end else begin
        in_check = 1'b1;
        exp_blk = 0;
        cnsty_chk_req_i = 1'b1;
        next_cycle();
        cnsty_chk_req_i = 1'b0;
        wait_status(1'b1);
        repeat (2) @(negedge clk_i);
        // Mismatch without bypass locks the partition and holds the ack
        if (t_corrupt[i] && !t_byp[i]) begin
          check_val("ack held in error", 1, cnsty_chk_ack_o);
          check_val("init_done_o after mismatch", 0, init_done_o);
        end else begin
          check_val("ack pulses", 1, ack_cnt);
          check_val("data_o after check", exp_data, data_o);
          check_val("read_lock_o after check", t_rd_lock[i], read_lock_o);
        end
      end
    end
    check_val("error_o", t_exp_err[i], error_o);
    check_val("fsm_err_o pulses", t_esc[i], fsm_err_cnt);
    $display("Test %0d %s finished with %0d errors", i, t_name[i],
             total_errors() - errs_before);
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {init_req_i, cnsty_chk_req_i, check_byp_en_i, escalate_en_i} = '0;
    {read_lock_i, write_lock_i, otp_gnt_i, otp_rvalid_i} = '0;
    otp_rdata_i = '0;
    otp_err_i = NoError;
    {in_check, done_seen, rd_pending, req_seen} = '0;
    {cur, exp_blk, err_cnt, check_cnt, fsm_err_cnt, ack_cnt, gnt_wait, rd_idx} = '0;
    lfsr_q = 32'ha60a;
    // name, err block, err code, corrupt, bypass, escalate, rd lock, wr lock, expected
    add_entry(0, "init_clean", -1, NoError, 0, 0, 0, 0, 1, NoError);
    add_entry(1, "check_bypass", -1, NoError, 1, 1, 0, 1, 0, NoError);
    add_entry(2, "check_mismatch", -1, NoError, 1, 0, 0, 0, 0, CheckFailError);
    add_entry(3, "ecc_corr", 2, MacroEccCorrError, 0, 0, 0, 1, 1, MacroEccCorrError);
    add_entry(4, "ecc_uncorr", 1, MacroEccUncorrError, 0, 0, 0, 0, 0, MacroEccUncorrError);
    add_entry(5, "escalate", -1, NoError, 0, 0, 1, 0, 0, FsmStateError);
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d checks, %0d errors", num_tests, check_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog allows 400 cycles per table entry
  initial begin
    #(num_tests * 400 * clk_period);
    $display("Timeout: the run did not finish in %0d cycles", num_tests * 400);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule : tb_otp_part_buf

`default_nettype wire

// File: verilog/otp_buf_if.sv
// Buffer register write and read port
`timescale 1ns/1ps
`default_nettype none

`include "otp_part_cfg.svh"

interface otp_buf_if;

  // Write strobe, takes effect on the next clock edge
  logic                   wr_en;
  // Block index for both write and read
  logic [`OTP_CNT_W-1:0]  idx;
  // Block as read from OTP
  logic [`OTP_BLOCK_W-1:0] wdata;
  // Buffered block at idx, combinational
  logic [`OTP_BLOCK_W-1:0] rdata;

  // Control side, fills the buffer and reads it back for the check
  modport fsm (
    output wr_en,
    output idx,
    output wdata,
    input  rdata
  );

  // Storage side
  modport regs (
    input  wr_en,
    input  idx,
    input  wdata,
    output rdata
  );

endinterface : otp_buf_if

`default_nettype wire

// File: verilog/otp_part_access.sv
// Partition lock and output gating
`timescale 1ns/1ps
`default_nettype none

`include "otp_part_cfg.svh"

module otp_part_access (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    unlock_i,
  input  logic                    lockdown_i,
  input  logic [`OTP_PART_W-1:0]  part_data_i,
  input  logic                    read_lock_i,
  input  logic                    write_lock_i,
  output logic                    read_lock_o,
  output logic                    write_lock_o,
  output logic                    init_done_o,
  output logic [`OTP_PART_W-1:0]  data_o
);

  // Partition stays locked until initialization completes
  logic locked_q;

  ////////////////////////////////////////////////////////////
  // Lock state
  ////////////////////////////////////////////////////////////

  // Lockdown takes priority over a coincident unlock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      locked_q <= 1'b1;
    end else if (lockdown_i) begin
      locked_q <= 1'b1;
    end else if (unlock_i) begin
      locked_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Access locks and gating
  ////////////////////////////////////////////////////////////

  // Software locks can only add to the hardware lock
  assign read_lock_o  = locked_q | read_lock_i;
  assign write_lock_o = locked_q | write_lock_i;

  assign init_done_o = ~locked_q;

  // Buffer contents hidden until unlocked
  assign data_o = init_done_o ? part_data_i : '0;

endmodule : otp_part_access

`default_nettype wire

// File: verilog/otp_part_buf.sv
// Buffered OTP partition
`timescale 1ns/1ps
`default_nettype none

`include "otp_part_cfg.svh"

module otp_part_buf
  import otp_part_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Control and life cycle
  input  logic                     init_req_i,
  input  logic                     cnsty_chk_req_i,
  input  logic                     check_byp_en_i,
  input  logic                     escalate_en_i,
  // Software locks
  input  logic                     read_lock_i,
  input  logic                     write_lock_i,
  // Status
  output logic                     init_done_o,
  output logic                     cnsty_chk_ack_o,
  output logic                     fsm_err_o,
  output otp_err_e                 error_o,
  output logic                     read_lock_o,
  output logic                     write_lock_o,
  output logic [`OTP_PART_W-1:0]   data_o,
  // OTP macro port
  output logic                     otp_req_o,
  output logic [`OTP_ADDR_W-1:0]   otp_addr_o,
  input  logic                     otp_gnt_i,
  input  logic                     otp_rvalid_i,
  input  logic [`OTP_BLOCK_W-1:0]  otp_rdata_i,
  input  otp_err_e                 otp_err_i
);

  logic                   unlock;
  logic                   lockdown;
  logic [`OTP_PART_W-1:0] part_data;

  // FSM to buffer write and compare path
  otp_buf_if u_buf_if ();

  otp_part_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .cnsty_chk_req_i (cnsty_chk_req_i),
    .check_byp_en_i  (check_byp_en_i),
    .escalate_en_i   (escalate_en_i),
    .cnsty_chk_ack_o (cnsty_chk_ack_o),
    .fsm_err_o       (fsm_err_o),
    .error_o         (error_o),
    .otp_req_o       (otp_req_o),
    .otp_addr_o      (otp_addr_o),
    .otp_gnt_i       (otp_gnt_i),
    .otp_rvalid_i    (otp_rvalid_i),
    .otp_rdata_i     (otp_rdata_i),
    .otp_err_i       (otp_err_i),
    .buf_o           (u_buf_if.fsm),
    .unlock_o        (unlock),
    .lockdown_o      (lockdown)
  );

  otp_part_buf_regs u_buf_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .buf_i       (u_buf_if.regs),
    .part_data_o (part_data)
  );

  otp_part_access u_access (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .unlock_i     (unlock),
    .lockdown_i   (lockdown),
    .part_data_i  (part_data),
    .read_lock_i  (read_lock_i),
    .write_lock_i (write_lock_i),
    .read_lock_o  (read_lock_o),
    .write_lock_o (write_lock_o),
    .init_done_o  (init_done_o),
    .data_o       (data_o)
  );

endmodule : otp_part_buf

`default_nettype wire

// File: verilog/otp_part_buf_regs.sv
// Partition buffer registers
`timescale 1ns/1ps
`default_nettype none

`include "otp_part_cfg.svh"

module otp_part_buf_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  otp_buf_if.regs                 buf_i,
  output logic [`OTP_PART_W-1:0]  part_data_o
);

  // One entry per partition block
  logic [`OTP_BLOCK_W-1:0] blocks_q [`OTP_NUM_BLOCKS];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `OTP_NUM_BLOCKS; i++) begin
        blocks_q[i] <= '0;
      end
    end else if (buf_i.wr_en) begin
      blocks_q[buf_i.idx] <= buf_i.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  // Indexed block for the consistency compare
  assign buf_i.rdata = blocks_q[buf_i.idx];

  // Flattened view, block 0 lowest
  always_comb begin
    part_data_o = '0;
    for (int i = 0; i < `OTP_NUM_BLOCKS; i++) begin
      part_data_o[i*`OTP_BLOCK_W +: `OTP_BLOCK_W] = blocks_q[i];
    end
  end

endmodule : otp_part_buf_regs

`default_nettype wire

// File: verilog/otp_part_fsm.sv
// OTP partition control FSM
`timescale 1ns/1ps
`default_nettype none

`include "otp_part_cfg.svh"

module otp_part_fsm
  import otp_part_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     init_req_i,
  input  logic                     cnsty_chk_req_i,
  input  logic                     check_byp_en_i,
  input  logic                     escalate_en_i,
  output logic                     cnsty_chk_ack_o,
  output logic                     fsm_err_o,
  output otp_err_e                 error_o,
  output logic                     otp_req_o,
  output logic [`OTP_ADDR_W-1:0]   otp_addr_o,
  input  logic                     otp_gnt_i,
  input  logic                     otp_rvalid_i,
  input  logic [`OTP_BLOCK_W-1:0]  otp_rdata_i,
  input  otp_err_e                 otp_err_i,
  otp_buf_if.fsm                   buf_o,
  output logic                     unlock_o,
  output logic                     lockdown_o
);

  // Byte address carries the halfword address plus the dropped low bits
  localparam int unsigned ByteAddrW  = `OTP_ADDR_W + `OTP_ADDR_SHIFT;
  localparam int unsigned BlockShift = $clog2(`OTP_BLOCK_W / 8);

  localparam logic [`OTP_CNT_W-1:0] LastBlock = `OTP_CNT_W'(`OTP_NUM_BLOCKS - 1);

  state_e                  state_d, state_q;
  otp_err_e                error_d, error_q;
  logic [`OTP_CNT_W-1:0]   cnt_q;
  logic                    cnt_en, cnt_clr;
  logic                    ok_resp;
  logic [ByteAddrW-1:0]    addr_byte;

  // Only a clean or corrected read may be used
  assign ok_resp = (otp_err_i == NoError) || (otp_err_i == MacroEccCorrError);

  ////////////////////////////////////////////////////////////
  // Next state logic
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    cnt_en          = 1'b0;
    cnt_clr         = 1'b0;
    otp_req_o       = 1'b0;
    buf_o.wr_en     = 1'b0;
    unlock_o        = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Wait for the one-time initialization pulse
      ResetSt: begin
        if (init_req_i) begin
          state_d = InitSt;
          cnt_clr = 1'b1;
        end
      end
      // Request held until granted, address stays on cnt_q
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      // Store the returned block, unlock after the last one
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          if (ok_resp) begin
            buf_o.wr_en = 1'b1;
            if (otp_err_i == MacroEccCorrError) begin
              error_d = MacroEccCorrError;
            end
            if (cnt_q == LastBlock) begin
              state_d  = IdleSt;
              unlock_o = 1'b1;
            end else begin
              state_d = InitSt;
              cnt_en  = 1'b1;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err_i;
          end
        end
      end
      // Partition usable, only a check request leaves here
      IdleSt: begin
        if (cnsty_chk_req_i) begin
          state_d = CnstyReadSt;
          cnt_clr = 1'b1;
        end
      end
      CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = CnstyReadWaitSt;
        end
      end
      // Compare OTP data against the buffer
      // Bypass is used by life cycle during transitions
      CnstyReadWaitSt: begin
        if (otp_rvalid_i) begin
          if (ok_resp) begin
            if (otp_err_i == MacroEccCorrError) begin
              error_d = MacroEccCorrError;
            end
            if (otp_rdata_i == buf_o.rdata || check_byp_en_i) begin
              if (cnt_q == LastBlock) begin
                state_d         = IdleSt;
                cnsty_chk_ack_o = 1'b1;
              end else begin
                state_d = CnstyReadSt;
                cnt_en  = 1'b1;
              end
            end else begin
              state_d         = ErrorSt;
              error_d         = CheckFailError;
              cnsty_chk_ack_o = 1'b1;
            end
          end else begin
            state_d         = ErrorSt;
            error_d         = otp_err_i;
            cnsty_chk_ack_o = 1'b1;
          end
        end
      end
      // Terminal, checks are acknowledged right away
      ErrorSt: begin
        cnsty_chk_ack_o = 1'b1;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched state encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
    endcase

    // Escalation overrides everything and blocks a late unlock
    if (escalate_en_i) begin
      state_d     = ErrorSt;
      unlock_o    = 1'b0;
      buf_o.wr_en = 1'b0;
      if (state_q != ErrorSt) begin
        fsm_err_o = 1'b1;
      end
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and buffer port
  ////////////////////////////////////////////////////////////

  // Blocks are 8 bytes apart, OTP takes halfword addresses
  assign addr_byte  = ByteAddrW'(`OTP_PART_OFFSET) + (ByteAddrW'(cnt_q) << BlockShift);
  assign otp_addr_o = addr_byte[ByteAddrW-1:`OTP_ADDR_SHIFT];

  assign buf_o.idx   = cnt_q;
  assign buf_o.wdata = otp_rdata_i;

  assign error_o    = error_q;
  assign lockdown_o = (state_q == ErrorSt);

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule : otp_part_fsm

`default_nettype wire

// File: verilog/otp_part_pkg.sv
// OTP partition types
`default_nettype none

package otp_part_pkg;

  // Error codes, shared with the OTP macro response
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    CheckFailError      = 3'h4,
    FsmStateError       = 3'h5
  } otp_err_e;

  // Partition control states
  // 3'h7 is unused and treated as a glitched state
  typedef enum logic [2:0] {
    ResetSt         = 3'h0,
    InitSt          = 3'h1,
    InitWaitSt      = 3'h2,
    IdleSt          = 3'h3,
    CnstyReadSt     = 3'h4,
    CnstyReadWaitSt = 3'h5,
    ErrorSt         = 3'h6
  } state_e;

endpackage : otp_part_pkg

`default_nettype wire
